/* hdl/cab_cfg.svh */
`ifndef CAB_CFG_SVH
`define CAB_CFG_SVH

// line geometry of the bridge
`define CAB_BEAT_W 32   // data bits per axi beat
`define CAB_BEATS  16   // beats in one cache line

// axi address and id widths
`define CAB_ADDR_W 32
`define CAB_ID_W   4    // ar_id carries the read source in bit 0

`endif

/* hdl/cab_pkg.sv */
package cab_pkg;

`include "cab_cfg.svh"

    // one axi data beat
    typedef logic [`CAB_BEAT_W-1:0] beat_t;

    // whole cache line, beat 0 in the lowest word
    typedef beat_t [`CAB_BEATS-1:0] line_t;

    typedef logic [`CAB_ADDR_W-1:0] addr_t; // byte address
    typedef logic [`CAB_ID_W-1:0]   axi_id_t;

    // owner of a read burst, value is the ar_id
    typedef enum logic
    {
        RD_SRC_IC = 1'b0,
        RD_SRC_DC = 1'b1
    } rd_src_e;

endpackage

/* hdl/beat_ctl_if.sv */
`timescale 1ns/1ns

`include "cab_cfg.svh"

interface beat_ctl_if;

    localparam int IDX_W = $clog2(`CAB_BEATS);

    logic             start;    // burst begins, clears the count
    logic             advance;  // beat accepted on the bus
    logic [IDX_W-1:0] idx;      // current beat
    logic             last;     // idx on final beat

    modport fsm (
        output start,
        output advance,
        input  last
    );

    modport cnt (
        input  start,
        input  advance,
        output idx,
        output last
    );

    modport data (
        input start,
        input advance,
        input idx
    );

endinterface

/* hdl/beat_counter.sv */
`timescale 1ns/1ns

`include "cab_cfg.svh"

module beat_counter (
    input logic aclk,
    input logic aresetn,
    beat_ctl_if.cnt ctl
);

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            ctl.idx <= '0;
        end
        else if (ctl.start)
        begin
            ctl.idx <= '0;                  // new burst
        end
        else if (ctl.advance)
        begin
            ctl.idx <= ctl.idx + 1'b1;      // only on an accepted beat
        end
    end

    // decoded from the index so it cannot drift from the beat count
    assign ctl.last = (ctl.idx == $bits(ctl.idx)'(`CAB_BEATS - 1));

endmodule

/* hdl/line_gather.sv */
`timescale 1ns/1ns

`include "cab_cfg.svh"

module line_gather (
    input  logic           aclk,
    input  logic           aresetn,
    input  cab_pkg::beat_t i_beat,
    beat_ctl_if.data       ctl,
    output cab_pkg::line_t o_line
);

    cab_pkg::line_t line_q;

    // beats enter at the top word and move down, so after a full
    // burst beat 0 sits in word 0
    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            line_q <= '0;
        end
        else if (ctl.start)
        begin
            line_q <= '0;                   // drop the previous line
        end
        else if (ctl.advance)
        begin
            line_q <= {i_beat, line_q[`CAB_BEATS-1:1]};
        end
    end

    assign o_line = line_q;     // stable until next start

endmodule

/* hdl/line_scatter.sv */
`timescale 1ns/1ns

`include "cab_cfg.svh"

module line_scatter (
    input  logic           aclk,
    input  logic           aresetn,
    input  logic           i_load,
    input  cab_pkg::line_t i_line,
    beat_ctl_if.data       ctl,
    output cab_pkg::beat_t o_beat
);

    cab_pkg::line_t line_q;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            line_q <= '0;
        end
        else if (i_load)
        begin
            line_q <= i_line;       // whole writeback line at once
        end
    end

    // the index only moves on an accepted beat, so under a w stall
    // the same word stays on the bus
    assign o_beat = line_q[ctl.idx];

endmodule

/* hdl/rd_channel_fsm.sv */
`timescale 1ns/1ns

module rd_channel_fsm (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             i_ic_req_valid,
    output logic             o_ic_req_ready,
    input  cab_pkg::addr_t   i_ic_addr,
    input  logic             i_dc_rd_valid,
    output logic             o_dc_rd_ready,
    input  cab_pkg::addr_t   i_dc_rd_addr,
    output cab_pkg::axi_id_t o_ar_id,
    output cab_pkg::addr_t   o_ar_addr,
    output logic             o_ar_valid,
    input  logic             i_ar_ready,
    input  cab_pkg::beat_t   i_r_data,
    input  logic             i_r_last,
    input  logic             i_r_valid,
    output logic             o_r_ready,
    output logic             o_ic_line_valid,
    output logic             o_dc_line_valid,
    output cab_pkg::line_t   o_line
);

    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_DONE} state_e;

    state_e           state;
    state_e           state_nxt;
    cab_pkg::addr_t   addr_q;
    cab_pkg::rd_src_e src_q;
    logic             ic_take;
    logic             dc_take;
    logic             r_beat;

    beat_ctl_if rd_ctl ();

    assign o_dc_rd_ready  = (state == ST_IDLE);
    assign o_ic_req_ready = (state == ST_IDLE) && !i_dc_rd_valid; // dcache wins a tie
    assign dc_take        = i_dc_rd_valid && o_dc_rd_ready;
    assign ic_take        = i_ic_req_valid && o_ic_req_ready;
    assign r_beat         = i_r_valid && o_r_ready;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (dc_take || ic_take) state_nxt = ST_ADDR;
            ST_ADDR: if (i_ar_ready) state_nxt = ST_DATA;
            // r_last or the counted final beat ends the burst, whichever comes first
            ST_DATA: if (r_beat && (i_r_last || rd_ctl.last)) state_nxt = ST_DONE;
            default: state_nxt = ST_IDLE;   // done lasts one cycle
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (dc_take)
        begin
            addr_q <= i_dc_rd_addr;
            src_q  <= cab_pkg::RD_SRC_DC;
        end
        else if (ic_take)
        begin
            addr_q <= i_ic_addr;
            src_q  <= cab_pkg::RD_SRC_IC;
        end
    end

    assign o_ar_valid = (state == ST_ADDR);
    assign o_ar_addr  = addr_q;
    assign o_ar_id    = cab_pkg::axi_id_t'(src_q);  // 0 icache, 1 dcache
    assign o_r_ready  = (state == ST_DATA);

    assign rd_ctl.start   = dc_take || ic_take;
    assign rd_ctl.advance = r_beat;

    // steer the finished line to its owner
    assign o_ic_line_valid = (state == ST_DONE) && (src_q == cab_pkg::RD_SRC_IC);
    assign o_dc_line_valid = (state == ST_DONE) && (src_q == cab_pkg::RD_SRC_DC);

    beat_counter u_beat_counter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ctl     (rd_ctl.cnt)
    );

    line_gather u_line_gather (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_beat  (i_r_data),
        .ctl     (rd_ctl.data),
        .o_line  (o_line)
    );

endmodule

/* hdl/wr_channel_fsm.sv */
`timescale 1ns/1ns

`include "cab_cfg.svh"

module wr_channel_fsm (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      i_dc_wr_valid,
    output logic                      o_dc_wr_ready,
    input  cab_pkg::addr_t            i_dc_wr_addr,
    input  cab_pkg::line_t            i_dc_wr_line,
    input  logic [`CAB_BEAT_W/8-1:0]  i_dc_wr_strb,
    output cab_pkg::addr_t            o_aw_addr,
    output logic                      o_aw_valid,
    input  logic                      i_aw_ready,
    output cab_pkg::beat_t            o_w_data,
    output logic [`CAB_BEAT_W/8-1:0]  o_w_strb,
    output logic                      o_w_last,
    output logic                      o_w_valid,
    input  logic                      i_w_ready,
    input  logic                      i_b_valid,
    output logic                      o_b_ready,
    output logic                      o_dc_wr_done
);

    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_RESP} state_e;

    state_e                   state;
    state_e                   state_nxt;
    cab_pkg::addr_t           addr_q;
    logic [`CAB_BEAT_W/8-1:0] strb_q;
    logic                     wr_take;
    logic                     w_beat;

    beat_ctl_if wr_ctl ();

    assign o_dc_wr_ready = (state == ST_IDLE);
    assign wr_take       = i_dc_wr_valid && o_dc_wr_ready;
    assign w_beat        = o_w_valid && i_w_ready;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (wr_take) state_nxt = ST_ADDR;
            ST_ADDR: if (i_aw_ready) state_nxt = ST_DATA;
            ST_DATA: if (w_beat && wr_ctl.last) state_nxt = ST_RESP;
            default: if (i_b_valid) state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (wr_take)
        begin
            addr_q <= i_dc_wr_addr;
            strb_q <= i_dc_wr_strb;     // same strobe on every beat
        end
    end

    assign o_aw_valid   = (state == ST_ADDR);
    assign o_aw_addr    = addr_q;
    assign o_w_valid    = (state == ST_DATA);
    assign o_w_strb     = strb_q;
    assign o_w_last     = o_w_valid && wr_ctl.last;
    assign o_b_ready    = (state == ST_RESP);
    assign o_dc_wr_done = i_b_valid && o_b_ready;   // pulse on b handshake

    assign wr_ctl.start   = wr_take;
    assign wr_ctl.advance = w_beat;

    beat_counter u_beat_counter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ctl     (wr_ctl.cnt)
    );

    line_scatter u_line_scatter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_load  (wr_take),
        .i_line  (i_dc_wr_line),
        .ctl     (wr_ctl.data),
        .o_beat  (o_w_data)
    );

endmodule

/* hdl/cache_axi_bridge.sv */
`timescale 1ns/1ns

`include "cab_cfg.svh"

module cache_axi_bridge (
    input  logic                      aclk,
    input  logic                      aresetn,

    // icache refill
    input  logic                      i_ic_req_valid,
    output logic                      o_ic_req_ready,
    input  cab_pkg::addr_t            i_ic_addr,
    output cab_pkg::line_t            o_ic_line,
    output logic                      o_ic_line_valid,

    // dcache refill
    input  logic                      i_dc_rd_valid,
    output logic                      o_dc_rd_ready,
    input  cab_pkg::addr_t            i_dc_rd_addr,
    output cab_pkg::line_t            o_dc_line,
    output logic                      o_dc_line_valid,

    // dcache writeback
    input  logic                      i_dc_wr_valid,
    output logic                      o_dc_wr_ready,
    input  cab_pkg::addr_t            i_dc_wr_addr,
    input  cab_pkg::line_t            i_dc_wr_line,
    input  logic [`CAB_BEAT_W/8-1:0]  i_dc_wr_strb,
    output logic                      o_dc_wr_done,

    // axi master, incr 16 x 4 bytes assumed by the slave
    output cab_pkg::axi_id_t          o_ar_id,
    output cab_pkg::addr_t            o_ar_addr,
    output logic                      o_ar_valid,
    input  logic                      i_ar_ready,
    input  cab_pkg::beat_t            i_r_data,
    input  logic                      i_r_last,
    input  logic                      i_r_valid,
    output logic                      o_r_ready,
    output cab_pkg::addr_t            o_aw_addr,
    output logic                      o_aw_valid,
    input  logic                      i_aw_ready,
    output cab_pkg::beat_t            o_w_data,
    output logic [`CAB_BEAT_W/8-1:0]  o_w_strb,
    output logic                      o_w_last,
    output logic                      o_w_valid,
    input  logic                      i_w_ready,
    input  logic                      i_b_valid,
    output logic                      o_b_ready
);

    cab_pkg::line_t rd_line;    // one gather buffer serves both caches

    assign o_ic_line = rd_line;
    assign o_dc_line = rd_line;

    rd_channel_fsm u_rd_channel (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .i_ic_req_valid  (i_ic_req_valid),
        .o_ic_req_ready  (o_ic_req_ready),
        .i_ic_addr       (i_ic_addr),
        .i_dc_rd_valid   (i_dc_rd_valid),
        .o_dc_rd_ready   (o_dc_rd_ready),
        .i_dc_rd_addr    (i_dc_rd_addr),
        .o_ar_id         (o_ar_id),
        .o_ar_addr       (o_ar_addr),
        .o_ar_valid      (o_ar_valid),
        .i_ar_ready      (i_ar_ready),
        .i_r_data        (i_r_data),
        .i_r_last        (i_r_last),
        .i_r_valid       (i_r_valid),
        .o_r_ready       (o_r_ready),
        .o_ic_line_valid (o_ic_line_valid),
        .o_dc_line_valid (o_dc_line_valid),
        .o_line          (rd_line)
    );

    wr_channel_fsm u_wr_channel (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_dc_wr_valid (i_dc_wr_valid),
        .o_dc_wr_ready (o_dc_wr_ready),
        .i_dc_wr_addr  (i_dc_wr_addr),
        .i_dc_wr_line  (i_dc_wr_line),
        .i_dc_wr_strb  (i_dc_wr_strb),
        .o_aw_addr     (o_aw_addr),
        .o_aw_valid    (o_aw_valid),
        .i_aw_ready    (i_aw_ready),
        .o_w_data      (o_w_data),
        .o_w_strb      (o_w_strb),
        .o_w_last      (o_w_last),
        .o_w_valid     (o_w_valid),
        .i_w_ready     (i_w_ready),
        .i_b_valid     (i_b_valid),
        .o_b_ready     (o_b_ready),
        .o_dc_wr_done  (o_dc_wr_done)
    );

endmodule

/* bench/axi_mem_model.sv */
`timescale 1ns/1ns

module axi_mem_model (
    input  logic           aclk,
    input  logic           aresetn,
    input  logic [2:0]     i_stall,     // stall odds out of 8
    input  cab_pkg::addr_t i_ar_addr,
    input  logic           i_ar_valid,
    output logic           o_ar_ready,
    output cab_pkg::beat_t o_r_data,
    output logic           o_r_last,
    output logic           o_r_valid,
    input  logic           i_r_ready,
    input  cab_pkg::addr_t i_aw_addr,
    input  logic           i_aw_valid,
    output logic           o_aw_ready,
    input  cab_pkg::beat_t i_w_data,
    input  logic [3:0]     i_w_strb,
    input  logic           i_w_last,
    input  logic           i_w_valid,
    output logic           o_w_ready,
    output logic           o_b_valid,
    input  logic           i_b_ready
);

    cab_pkg::beat_t mem [1024];
    integer         seed = 73966;
    logic           rd_busy, wr_busy, b_pend, go_rd, go_wr;
    logic [9:0]     rd_ptr, wr_ptr;
    logic [3:0]     rd_cnt;

    initial
    begin
        for (int k = 0; k < 1024; k++)
            mem[k] = k * 32'h9E37_79B1;     // word k holds k times a constant
    end

    assign o_r_data = mem[rd_ptr];
    assign o_r_last = (rd_cnt == 4'd15);

    always @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            {o_ar_ready, o_r_valid, rd_busy, rd_ptr, rd_cnt} <= '0;
            {o_aw_ready, o_w_ready, o_b_valid, wr_busy, b_pend, wr_ptr} <= '0;
        end
        else
        begin
            go_rd = ({$random(seed)} % 8) >= i_stall;
            go_wr = ({$random(seed)} % 8) >= i_stall;
            if (!rd_busy)
            begin
                o_ar_ready <= go_rd;
                if (i_ar_valid && o_ar_ready)
                begin
                    {rd_busy, o_ar_ready} <= 2'b10;
                    rd_ptr <= i_ar_addr[11:2];
                    rd_cnt <= '0;
                end
            end
            else if (o_r_valid && i_r_ready)
            begin
                o_r_valid <= 1'b0;
                rd_ptr    <= rd_ptr + 1'b1;
                rd_cnt    <= rd_cnt + 1'b1;
                if (o_r_last)
                    rd_busy <= 1'b0;
            end
            else if (!o_r_valid)
                o_r_valid <= go_rd;         // once up it holds until ready
            if (!wr_busy)
            begin
                o_aw_ready <= go_wr;
                if (i_aw_valid && o_aw_ready)
                begin
                    {wr_busy, o_aw_ready} <= 2'b10;
                    wr_ptr <= i_aw_addr[11:2];
                end
            end
            else if (!b_pend)
            begin
                o_w_ready <= go_wr;
                if (i_w_valid && o_w_ready)
                begin
                    for (int i = 0; i < 4; i++)
                        if (i_w_strb[i])
                            mem[wr_ptr][8*i +: 8] <= i_w_data[8*i +: 8];
                    wr_ptr <= wr_ptr + 1'b1;
                    if (i_w_last)
                        {b_pend, o_w_ready} <= 2'b10;
                end
            end
            else if (o_b_valid && i_b_ready)
                {o_b_valid, b_pend, wr_busy} <= '0;
            else if (!o_b_valid)
                o_b_valid <= go_wr;
        end
    end

endmodule

/* bench/cache_axi_bridge_props.sv */
`timescale 1ns/1ns

module cache_axi_bridge_props (
    input logic           aclk,
    input logic           aresetn,
    input logic           ar_valid, ar_ready, aw_valid, aw_ready,
    input logic           w_valid, w_ready, w_last,
    input logic           ic_line_valid, dc_line_valid,
    input cab_pkg::addr_t ar_addr, aw_addr,
    input cab_pkg::beat_t w_data
);

    logic [3:0] w_cnt;
    int         fail_cnt = 0;   // failed assertions so far

    always @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            w_cnt <= '0;
        else if (w_valid && w_ready)
            w_cnt <= w_last ? 4'd0 : w_cnt + 1'b1;
    end

    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else
    begin
        fail_cnt++;
        $error("ar_valid or ar_addr changed before ar_ready");
    end
    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
    else
    begin
        fail_cnt++;
        $error("aw_valid or aw_addr changed before aw_ready");
    end
    w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        w_valid && !w_ready |=> w_valid && $stable(w_data))
    else
    begin
        fail_cnt++;
        $error("w_valid or w_data changed before w_ready");
    end
    w_last_pos: assert property (@(posedge aclk) disable iff (!aresetn)
        w_valid && w_ready |-> (w_last == (w_cnt == 4'd15)))
    else
    begin
        fail_cnt++;
        $error("w_last not on the 16th beat");
    end
    line_vs_ar: assert property (@(posedge aclk) disable iff (!aresetn)
        !((ic_line_valid || dc_line_valid) && ar_valid))
    else
    begin
        fail_cnt++;
        $error("line_valid high while ar_valid is high");
    end

endmodule

bind cache_axi_bridge cache_axi_bridge_props u_props (
    .aclk (aclk), .aresetn (aresetn),
    .ar_valid (o_ar_valid), .ar_ready (i_ar_ready),
    .aw_valid (o_aw_valid), .aw_ready (i_aw_ready),
    .w_valid (o_w_valid), .w_ready (i_w_ready), .w_last (o_w_last),
    .ic_line_valid (o_ic_line_valid), .dc_line_valid (o_dc_line_valid),
    .ar_addr (o_ar_addr), .aw_addr (o_aw_addr), .w_data (o_w_data)
);

/* bench/tb_cache_axi_bridge.sv */
`timescale 1ns/1ns

`include "cab_cfg.svh"

module tb_cache_axi_bridge;

    localparam int CYCLE_LIMIT = 4 * 11 * 400;  // 11 bursts, 400 cycles worst each

    logic aclk, aresetn, i_ic_req_valid, i_dc_rd_valid, i_dc_wr_valid;
    logic o_ic_req_ready, o_dc_rd_ready, o_dc_wr_ready, o_dc_wr_done;
    logic o_ic_line_valid, o_dc_line_valid;
    cab_pkg::addr_t i_ic_addr, i_dc_rd_addr, i_dc_wr_addr, o_ar_addr, o_aw_addr;
    cab_pkg::line_t o_ic_line, o_dc_line, i_dc_wr_line;
    logic [3:0]     i_dc_wr_strb, o_w_strb;
    cab_pkg::axi_id_t o_ar_id;
    cab_pkg::beat_t i_r_data, o_w_data, ref_mem [1024];
    logic i_ar_ready, o_ar_valid, i_r_last, i_r_valid, o_r_ready, o_aw_valid;
    logic i_aw_ready, o_w_last, o_w_valid, i_w_ready, i_b_valid, o_b_ready;
    logic [2:0] stall;
    integer seed = 73966;
    int err_cnt = 0, check_cnt = 0, test_cnt = 0, cycles = 0;
    int ic_done = 0, dc_done = 0, wr_done = 0;
    cab_pkg::addr_t ic_pend[$], dc_pend[$];
    int ar_ids[$], done_src[$];

    initial
    begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    cache_axi_bridge dut_i (.*);

    axi_mem_model u_mem (
        .aclk (aclk), .aresetn (aresetn), .i_stall (stall),
        .i_ar_addr (o_ar_addr), .i_ar_valid (o_ar_valid), .o_ar_ready (i_ar_ready),
        .o_r_data (i_r_data), .o_r_last (i_r_last), .o_r_valid (i_r_valid),
        .i_r_ready (o_r_ready), .i_aw_addr (o_aw_addr), .i_aw_valid (o_aw_valid),
        .o_aw_ready (i_aw_ready), .i_w_data (o_w_data), .i_w_strb (o_w_strb),
        .i_w_last (o_w_last), .i_w_valid (o_w_valid), .o_w_ready (i_w_ready),
        .o_b_valid (i_b_valid), .i_b_ready (o_b_ready)
    );

    // line at a byte address, writes already merged into ref_mem
    function automatic cab_pkg::line_t expected_line(input cab_pkg::addr_t a);
        cab_pkg::line_t l;
        for (int b = 0; b < `CAB_BEATS; b++)
            l[b] = ref_mem[10'(a[11:2] + b)];
        return l;
    endfunction

    task automatic check_value(input string name, input logic [511:0] exp, act);
        check_cnt++;
        if (exp !== act)
        begin
            err_cnt++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_ar_id(input string name, input int exp);
        if (ar_ids.size() == 0)
        begin
            err_cnt++;
            $display("%s: no AR handshake was seen", name);
        end
        else
            check_value(name, exp, ar_ids.pop_front());
    endtask

    // compares returned lines with the reference as they arrive
    always @(negedge aclk)
    begin
        if (aresetn)
        begin
            if (o_ar_valid && i_ar_ready)
                ar_ids.push_back(int'(o_ar_id));
            if (o_ic_line_valid || o_dc_line_valid)
            begin
                if (o_ic_line_valid ? ic_pend.size() == 0 : dc_pend.size() == 0)
                begin
                    err_cnt++;
                    $display("a line came back with no request pending");
                end
                else if (o_ic_line_valid)
                    check_value("ic_line", expected_line(ic_pend.pop_front()), o_ic_line);
                else
                    check_value("dc_line", expected_line(dc_pend.pop_front()), o_dc_line);
                done_src.push_back(o_dc_line_valid);
                ic_done += o_ic_line_valid;
                dc_done += o_dc_line_valid;
            end
            wr_done += o_dc_wr_done;
        end
    end

    always @(posedge aclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("run timed out after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic request_read(input logic is_dc, input cab_pkg::addr_t a);
        if (is_dc)
            dc_pend.push_back(a);
        else
            ic_pend.push_back(a);
        @(negedge aclk);
        if (is_dc)
            {i_dc_rd_valid, i_dc_rd_addr} = {1'b1, a};
        else
            {i_ic_req_valid, i_ic_addr} = {1'b1, a};
        #1;
        while (!(is_dc ? o_dc_rd_ready : o_ic_req_ready))
        begin
            @(negedge aclk);
            #1;
        end
        @(negedge aclk);
        if (is_dc)
            i_dc_rd_valid = 1'b0;
        else
            i_ic_req_valid = 1'b0;
    endtask

    task automatic write_line(input cab_pkg::addr_t a, input logic [3:0] strb);
        cab_pkg::line_t l;
        for (int b = 0; b < `CAB_BEATS; b++)
        begin
            l[b] = $random(seed);
            for (int i = 0; i < 4; i++)
                if (strb[i])
                    ref_mem[10'(a[11:2] + b)][8*i +: 8] = l[b][8*i +: 8];
        end
        @(negedge aclk);
        {i_dc_wr_valid, i_dc_wr_addr, i_dc_wr_line, i_dc_wr_strb} = {1'b1, a, l, strb};
        #1;
        while (!o_dc_wr_ready)
        begin
            @(negedge aclk);
            #1;
        end
        @(negedge aclk);
        i_dc_wr_valid = 1'b0;
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        $display("%s finished with %0d errors", name, err_cnt - errs_before);
    endtask

    initial
    begin
        int e;
        int w0;
        {aresetn, i_ic_req_valid, i_dc_rd_valid, i_dc_wr_valid} = '0;
        {i_ic_addr, i_dc_rd_addr, i_dc_wr_addr, i_dc_wr_line, i_dc_wr_strb} = '0;
        stall = 3'd2;
        for (int k = 0; k < 1024; k++)
            ref_mem[k] = k * 32'h9E37_79B1;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        e = err_cnt;
        request_read(1'b0, 32'h100);
        wait (ic_done == 1);
        check_ar_id("ic_refill_ar_id", 0);
        end_test("ic_refill", e);
        e = err_cnt;
        request_read(1'b1, 32'h180);
        wait (dc_done == 1);
        check_ar_id("dc_refill_ar_id", 1);
        check_value("dc_refill_ic_count", 1, ic_done);
        end_test("dc_refill", e);
        e = err_cnt;
        done_src.delete();
        fork
            request_read(1'b0, 32'h200);
            request_read(1'b1, 32'h300);
        join
        wait (ic_done == 2 && dc_done == 2);
        check_value("tie_first_src", 1, done_src[0]);
        check_value("tie_second_src", 0, done_src[1]);
        check_ar_id("tie_first_id", 1);
        check_ar_id("tie_second_id", 0);
        end_test("tie_dc_first", e);
        e = err_cnt;
        w0 = wr_done;
        write_line(32'h400, 4'hF);
        wait (wr_done == w0 + 1);
        request_read(1'b1, 32'h400);
        wait (dc_done == 3);
        repeat (8) @(negedge aclk);
        check_value("wb_done_count", w0 + 1, wr_done);
        check_ar_id("wb_read_id", 1);
        end_test("full_writeback", e);
        e = err_cnt;
        write_line(32'h400, 4'b0101);
        wait (wr_done == w0 + 2);
        request_read(1'b1, 32'h400);
        wait (dc_done == 4);
        check_ar_id("partial_read_id", 1);
        end_test("partial_writeback", e);
        e = err_cnt;
        stall = 3'd6;
        fork
            write_line(32'h600, 4'hF);
            request_read(1'b0, 32'h700);
        join
        wait (wr_done == w0 + 3 && ic_done == 3);
        stall = 3'd2;
        request_read(1'b1, 32'h600);
        wait (dc_done == 5);
        check_ar_id("overlap_ic_id", 0);
        check_ar_id("overlap_dc_id", 1);
        end_test("overlap_stalls", e);
        err_cnt += dut_i.u_props.fail_cnt;  // bound handshake assertions
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* build.f */
+incdir+hdl
hdl/cab_pkg.sv
hdl/beat_ctl_if.sv
hdl/beat_counter.sv
hdl/line_gather.sv
hdl/line_scatter.sv
hdl/rd_channel_fsm.sv
hdl/wr_channel_fsm.sv
hdl/cache_axi_bridge.sv
bench/axi_mem_model.sv
bench/cache_axi_bridge_props.sv
bench/tb_cache_axi_bridge.sv

/* Bender.yml */
package:
  name: cache_axi_bridge

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cab_pkg.sv
      - hdl/beat_ctl_if.sv
      - hdl/beat_counter.sv
      - hdl/line_gather.sv
      - hdl/line_scatter.sv
      - hdl/rd_channel_fsm.sv
      - hdl/wr_channel_fsm.sv
      - hdl/cache_axi_bridge.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/axi_mem_model.sv
      - bench/cache_axi_bridge_props.sv
      - bench/tb_cache_axi_bridge.sv
